//--- filelist.f
verilog/countdown_pkg.sv
verilog/apb_regs.sv
verilog/tick_timer.sv
verilog/countdown_fsm.sv
verilog/glyph_rom.sv
verilog/matrix_scan.sv
verilog/countdown_display.sv
test/tb_countdown_display.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f filelist.f --top-module tb_countdown_display -o sim_tb \
    > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/sim_tb > sim.log 2>&1 || { echo "simulation did not run"; exit 1; }
grep -q "Done: errors found" sim.log && { echo "FAIL, see sim.log"; exit 1; } || true
grep -q "Done: no errors" sim.log && echo "PASS" || { echo "FAIL, see sim.log"; exit 1; }

//--- test/tb_countdown_display.sv
`timescale 1ns/10ps

module tb_countdown_display import countdown_pkg::*; ();

    typedef struct packed {
        logic [DIV_W-1:0]        div;
        logic                    pause;
        logic                    restart;
        logic [5:0][DIGIT_W-1:0] seq;       // seq[0] is the first digit shown
    } test_t;

    localparam int N_TESTS = 3;
    localparam logic [5:0][DIGIT_W-1:0] SEQ = {3'd0, 3'd1, 3'd2, 3'd3, 3'd4, 3'd5};

    // divisor, pause, restart, expected digits
    test_t tests [N_TESTS] = '{
        '{16'd40, 1'b0, 1'b0, SEQ},
        '{16'd60, 1'b1, 1'b0, SEQ},
        '{16'd30, 1'b0, 1'b1, SEQ}
    };

    // glyph rows for digits 1 to 5, row 0 blank
    logic [7:0] glyph_tab [5][8] = '{
        '{8'h00, 8'h18, 8'h38, 8'h18, 8'h18, 8'h18, 8'h18, 8'h3C},
        '{8'h00, 8'h3C, 8'h66, 8'h06, 8'h0C, 8'h30, 8'h60, 8'h7E},
        '{8'h00, 8'h3C, 8'h66, 8'h06, 8'h1C, 8'h06, 8'h66, 8'h3C},
        '{8'h00, 8'h0C, 8'h1C, 8'h2C, 8'h4C, 8'h7E, 8'h0C, 8'h0C},
        '{8'h00, 8'h7E, 8'h60, 8'h7C, 8'h06, 8'h06, 8'h66, 8'h3C}
    };

    logic             clk = 1'b0;
    logic             rst = 1'b1;
    apb_req_t         apb_req = '0;
    apb_rsp_t         apb_rsp;
    logic [ROW_N-1:0] row;
    logic [ROW_N-1:0] colr;
    logic [ROW_N-1:0] colg;

    int               errors = 0;
    int               checks = 0;
    int               cycles = 0;
    int               limit = 0;
    logic             mon_on = 1'b0;
    logic [2:0]       prev_digit = '0;
    logic [ROW_N-1:0] rows_seen = '0;
    int               win_cnt = 0;

    countdown_display i_dut (
        .clk     (clk),
        .rst     (rst),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp),
        .row     (row),
        .colr    (colr),
        .colg    (colg)
    );

    always #2 clk = ~clk;

    task automatic check(input logic ok, input string msg);
        checks++;
        assert (ok) else
        begin
            errors++;
            $display("Error: %0t ns: %s", $time, msg);
        end
    endtask

    function automatic logic [7:0] exp_red(input int d, input int k);
        if (d >= 2 && d <= 5)               // 5,4 red and 3,2 yellow
            return glyph_tab[d-1][k];
        return 8'h00;
    endfunction

    function automatic logic [7:0] exp_green(input int d, input int k);
        if (d >= 1 && d <= 3)               // 3,2 yellow and 1 green
            return glyph_tab[d-1][k];
        return 8'h00;
    endfunction

    task automatic apb_xfer(input logic wr, input logic [3:0] addr, input logic [15:0] wdata,
                            output logic [15:0] rdata, output logic err);
        @(posedge clk);
        apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: wdata};
        @(posedge clk);
        apb_req.penable <= 1'b1;
        @(negedge clk);
        rdata = apb_rsp.prdata;
        err   = apb_rsp.pslverr;
        check(apb_rsp.pready, "pready is low in the access phase");
        @(posedge clk);
        apb_req <= '0;
    endtask

    task automatic apb_write(input logic [3:0] addr, input logic [15:0] data, output logic err);
        logic [15:0] unused;
        apb_xfer(1'b1, addr, data, unused, err);
    endtask

    task automatic apb_read(input logic [3:0] addr, output logic [15:0] data, output logic err);
        apb_xfer(1'b0, addr, 16'h0, data, err);
    endtask

    // outputs at this edge carry the digit seen one cycle earlier
    always @(negedge clk)
    begin
        if (mon_on)
        begin
            check($onehot(row), $sformatf("row 0x%02h is not one-hot", row));
            for (int k = 0; k < ROW_N; k++)
                if (row[k])
                    check(colr == exp_red(prev_digit, k) && colg == exp_green(prev_digit, k),
                          $sformatf("digit %0d row %0d: red 0x%02h green 0x%02h",
                                    prev_digit, k, colr, colg));
            rows_seen = rows_seen | row;
            win_cnt++;
            if (win_cnt == ROW_N * SCAN_DIV)
            begin
                check(rows_seen == 8'hFF, $sformatf("rows seen 0x%02h in a scan", rows_seen));
                rows_seen = '0;
                win_cnt = 0;
            end
        end
        prev_digit = i_dut.status.digit;
    end

    always @(posedge clk)
    begin
        cycles++;
        if (limit > 0 && cycles >= limit)
        begin
            $display("Timeout: the run did not finish within %0d cycles", limit);
            $display("Done: errors found");
            $finish;
        end
    end

    task automatic run_test(input int t);
        logic [15:0] st;
        logic        err;
        int          idx;
        int          err0;
        bit          seen [6];
        bit          paused;
        bit          restarted;
        logic [2:0]  held;
        err0 = errors;
        idx = 0;
        paused = 0;
        restarted = 0;
        foreach (seen[i])
            seen[i] = 0;
        apb_write(ADDR_DIV, tests[t].div, err);
        apb_write(ADDR_CTRL, 16'h1, err);
        do
        begin
            apb_read(ADDR_STATUS, st, err);
            if (idx < 5 && st[2:0] == tests[t].seq[idx+1])
                idx++;
            check(st[2:0] == tests[t].seq[idx],
                  $sformatf("digit %0d out of order, expected %0d", st[2:0], tests[t].seq[idx]));
            check(st[2:0] == 3'd0 || !st[5], "done flag set while the count runs");
            seen[idx] = 1;
            if (st[2:0] == 3'd3 && tests[t].pause && !paused)
            begin
                paused = 1;
                apb_write(ADDR_CTRL, 16'h2, err);
                apb_read(ADDR_STATUS, st, err);
                held = st[2:0];
                check(st[4:3] == 2'(PAUSE), "state is not PAUSE after pause was set");
                repeat (3 * tests[t].div) @(posedge clk);
                apb_read(ADDR_STATUS, st, err);
                check(st[2:0] == held, "digit moved while paused");
                apb_write(ADDR_CTRL, 16'h0, err);
            end
            if (st[2:0] == 3'd3 && tests[t].restart && !restarted)
            begin
                restarted = 1;
                apb_write(ADDR_CTRL, 16'h1, err);
                apb_read(ADDR_STATUS, st, err);
                check(st[2:0] == 3'd5 && !st[5], "restart did not return to digit 5");
                idx = 0;
            end
        end
        while (!(st[4:3] == 2'(IDLE) && st[2:0] == 3'd0));
        check(st[5], "done flag not set at the end of the count");
        foreach (seen[i])
            check(seen[i], $sformatf("digit %0d never seen", tests[t].seq[i]));
        $display("test %0d div %0d pause %0d restart %0d: %s", t, tests[t].div,
                 tests[t].pause, tests[t].restart, (errors == err0) ? "ok" : "failed");
    endtask

    initial
    begin
        logic [15:0] data;
        logic [15:0] val;
        logic        err;
        int          err0;
        void'($urandom(48));
        for (int t = 0; t < N_TESTS; t++)
            limit += tests[t].div * 6 + 200;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        mon_on = 1'b1;

        err0 = errors;
        apb_read(ADDR_STATUS, data, err);
        check(data == 16'h0 && !err, $sformatf("STATUS after reset reads 0x%04h", data));
        for (int i = 0; i < 4; i++)
        begin
            val = 16'($urandom % 400 + 1);
            apb_write(ADDR_DIV, val, err);
            apb_read(ADDR_DIV, data, err);
            check(data == val, $sformatf("DIV reads 0x%04h, wrote 0x%04h", data, val));
        end
        apb_read(4'hC, data, err);
        check(err, "no pslverr on an unmapped address");
        apb_write(ADDR_STATUS, 16'h1, err);
        check(err, "no pslverr on a write to STATUS");
        $display("register test: %s", (errors == err0) ? "ok" : "failed");

        for (int t = 0; t < N_TESTS; t++)
            run_test(t);

        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

//--- verilog/countdown_display.sv
`timescale 1ns/10ps

module countdown_display import countdown_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    input  apb_req_t         apb_req,
    output apb_rsp_t         apb_rsp,
    output logic [ROW_N-1:0] row,
    output logic [ROW_N-1:0] colr,
    output logic [ROW_N-1:0] colg
);

    cd_ctrl_t         ctrl;
    cd_status_t       status;
    logic             tick;
    logic             scan_en;
    logic [ROW_W-1:0] row_idx;
    pixel_row_t       pixels;

    apb_regs i_apb_regs (
        .clk     (clk),
        .rst     (rst),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp),
        .status  (status),
        .ctrl    (ctrl)
    );

    tick_timer i_tick_timer (
        .clk     (clk),
        .rst     (rst),
        .ctrl    (ctrl),
        .state   (status.state),
        .tick    (tick),
        .scan_en (scan_en)
    );

    countdown_fsm i_countdown_fsm (
        .clk    (clk),
        .rst    (rst),
        .ctrl   (ctrl),
        .tick   (tick),
        .status (status)
    );

    glyph_rom i_glyph_rom (
        .digit   (status.digit),
        .row_idx (row_idx),
        .pixels  (pixels)
    );

    matrix_scan i_matrix_scan (
        .clk     (clk),
        .rst     (rst),
        .scan_en (scan_en),
        .pixels  (pixels),
        .row_idx (row_idx),
        .row     (row),
        .colr    (colr),
        .colg    (colg)
    );

endmodule

//--- verilog/matrix_scan.sv
`timescale 1ns/10ps

module matrix_scan import countdown_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    input  logic             scan_en,
    input  pixel_row_t       pixels,
    output logic [ROW_W-1:0] row_idx,
    output logic [ROW_N-1:0] row,
    output logic [ROW_N-1:0] colr,
    output logic [ROW_N-1:0] colg
);

    logic [ROW_W-1:0] row_count;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            row_count <= '0;
        else if (scan_en)
            row_count <= row_count + ROW_W'(1);       // wraps after row 7
    end

    assign row_idx = row_count;

    // row select and its columns load on the same edge
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            row  <= ROW_N'(1);
            colr <= '0;
            colg <= '0;
        end
        else
        begin
            row  <= ROW_N'(1) << row_count;
            colr <= pixels.red;
            colg <= pixels.green;
        end
    end

endmodule

//--- verilog/glyph_rom.sv
`timescale 1ns/10ps

module glyph_rom import countdown_pkg::*; (
    input  logic [DIGIT_W-1:0] digit,
    input  logic [ROW_W-1:0]   row_idx,
    output pixel_row_t         pixels
);

    logic               lit;
    logic [DIGIT_W-1:0] glyph_sel;
    logic [ROW_N-1:0]   bits;

    // digit 0, out-of-range digits and row 0 stay dark
    assign lit = (digit != '0) && (digit <= DIGIT_W'(START_DIGIT)) && (row_idx != '0);
    assign glyph_sel = digit - DIGIT_W'(1);

    always_comb
    begin
        bits         = '0;
        pixels.red   = '0;
        pixels.green = '0;
        if (lit)
        begin
            bits = GLYPH[glyph_sel][row_idx];
            if (RED_DIGITS[glyph_sel])
                pixels.red = bits;
            if (GREEN_DIGITS[glyph_sel])
                pixels.green = bits;                  // red plus green shows yellow
        end
    end

endmodule

//--- verilog/countdown_fsm.sv
`timescale 1ns/10ps

module countdown_fsm import countdown_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  cd_ctrl_t   ctrl,
    input  logic       tick,
    output cd_status_t status
);

    cd_state_t          state_q;
    logic [DIGIT_W-1:0] digit_q;
    logic               done_q;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            state_q <= IDLE;
            digit_q <= '0;
            done_q  <= 1'b0;
        end
        else if (ctrl.start)
        begin
            state_q <= COUNT;                         // restart from any state
            digit_q <= DIGIT_W'(START_DIGIT);
            done_q  <= 1'b0;
        end
        else
        begin
            case (state_q)
                COUNT:
                begin
                    if (tick && digit_q == DIGIT_W'(1))
                    begin
                        digit_q <= '0;
                        done_q  <= 1'b1;
                        state_q <= IDLE;
                    end
                    else
                    begin
                        if (tick)
                            digit_q <= digit_q - DIGIT_W'(1);
                        if (ctrl.pause)
                            state_q <= PAUSE;
                    end
                end
                PAUSE:
                begin
                    if (!ctrl.pause)
                        state_q <= COUNT;
                end
                default:
                begin
                    state_q <= IDLE;                  // wait for start
                end
            endcase
        end
    end

    assign status = '{done: done_q, state: state_q, digit: digit_q};

endmodule

//--- verilog/tick_timer.sv
`timescale 1ns/10ps

module tick_timer import countdown_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  cd_ctrl_t  ctrl,
    input  cd_state_t state,
    output logic      tick,
    output logic      scan_en
);

    logic              counting;
    logic [DIV_W-1:0]  cnt_q;
    logic              tick_q;
    logic [SCAN_W-1:0] scan_cnt;

    assign counting = (state == COUNT) && !ctrl.pause;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            cnt_q  <= '0;
            tick_q <= 1'b0;
        end
        else if (ctrl.start)
        begin
            cnt_q  <= ctrl.div - DIV_W'(1);           // prescaler restarts
            tick_q <= 1'b0;
        end
        else if (counting)
        begin
            if (cnt_q == '0)
            begin
                cnt_q  <= ctrl.div - DIV_W'(1);
                tick_q <= 1'b1;
            end
            else
            begin
                cnt_q  <= cnt_q - DIV_W'(1);
                tick_q <= 1'b0;
            end
        end
        else
            tick_q <= 1'b0;                           // count holds while paused
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            scan_cnt <= '0;
        else
            scan_cnt <= scan_cnt + SCAN_W'(1);
    end

    assign tick    = tick_q;
    assign scan_en = (scan_cnt == SCAN_W'(SCAN_DIV - 1));

endmodule

//--- verilog/apb_regs.sv
`timescale 1ns/10ps

module apb_regs import countdown_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  apb_req_t   apb_req,
    output apb_rsp_t   apb_rsp,
    input  cd_status_t status,
    output cd_ctrl_t   ctrl
);

    logic             access;
    logic             wr;
    logic             is_ctrl;
    logic             is_div;
    logic             is_status;
    logic             start_q;
    logic             pause_q;
    logic [DIV_W-1:0] div_q;

    assign access    = apb_req.psel & apb_req.penable;
    assign wr        = access & apb_req.pwrite;
    assign is_ctrl   = (apb_req.paddr == ADDR_CTRL);
    assign is_div    = (apb_req.paddr == ADDR_DIV);
    assign is_status = (apb_req.paddr == ADDR_STATUS);

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            start_q <= 1'b0;
            pause_q <= 1'b0;
            div_q   <= DIV_W'(1);
        end
        else
        begin
            start_q <= wr & is_ctrl & apb_req.pwdata[0];   // one cycle only
            if (wr && is_ctrl)
                pause_q <= apb_req.pwdata[1];
            if (wr && is_div)
                div_q <= apb_req.pwdata;
        end
    end

    // read mux, valid in the access phase only
    always_comb
    begin
        apb_rsp.prdata  = '0;
        apb_rsp.pready  = 1'b1;                       // no wait states
        apb_rsp.pslverr = 1'b0;
        if (access)
        begin
            if (!is_ctrl && !is_div && !is_status)
                apb_rsp.pslverr = 1'b1;
            else if (is_status && apb_req.pwrite)
                apb_rsp.pslverr = 1'b1;               // STATUS is read-only
            else if (!apb_req.pwrite)
            begin
                if (is_ctrl)
                    apb_rsp.prdata = {{(DATA_W-2){1'b0}}, pause_q, 1'b0};
                else if (is_div)
                    apb_rsp.prdata = div_q;
                else
                    apb_rsp.prdata = {{(DATA_W-$bits(cd_status_t)){1'b0}}, status};
            end
        end
    end

    assign ctrl = '{
        start: start_q,
        pause: pause_q,
        div:   (div_q == '0) ? DIV_W'(1) : div_q
    };

endmodule

//--- verilog/countdown_pkg.sv
package countdown_pkg;

    localparam int DIGIT_W     = 3;
    localparam int ROW_N       = 8;
    localparam int ROW_W       = 3;
    localparam int START_DIGIT = 5;
    localparam int DIV_W       = 16;
    localparam int SCAN_DIV    = 4;
    localparam int SCAN_W      = 2;             // width of the scan prescaler
    localparam int DATA_W      = 16;
    localparam int ADDR_W      = 4;

    localparam logic [ADDR_W-1:0] ADDR_CTRL   = 4'h0;
    localparam logic [ADDR_W-1:0] ADDR_DIV    = 4'h4;
    localparam logic [ADDR_W-1:0] ADDR_STATUS = 4'h8;

    typedef struct packed {
        logic              psel;
        logic              penable;
        logic              pwrite;
        logic [ADDR_W-1:0] paddr;
        logic [DATA_W-1:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [DATA_W-1:0] prdata;
        logic              pready;
        logic              pslverr;
    } apb_rsp_t;

    typedef struct packed {
        logic [ROW_N-1:0] red;
        logic [ROW_N-1:0] green;
    } pixel_row_t;

    typedef enum logic [1:0] {
        IDLE,
        COUNT,
        PAUSE
    } cd_state_t;

    typedef struct packed {
        logic             start;                // single-cycle pulse
        logic             pause;                // level
        logic [DIV_W-1:0] div;
    } cd_ctrl_t;

    // field order gives the STATUS layout: done in bit 5, state 4:3, digit 2:0
    typedef struct packed {
        logic               done;
        cd_state_t          state;
        logic [DIGIT_W-1:0] digit;
    } cd_status_t;

    // colour rule, bit d-1 for digit d: 5,4 red, 3,2 yellow, 1 green
    localparam logic [START_DIGIT-1:0] RED_DIGITS   = 5'b11110;
    localparam logic [START_DIGIT-1:0] GREEN_DIGITS = 5'b00111;

    // glyphs for digits 1 to 5, row 0 left blank
    localparam logic [ROW_N-1:0] GLYPH [START_DIGIT][ROW_N] = '{
        '{8'b0000_0000, 8'b0001_1000, 8'b0011_1000, 8'b0001_1000,
          8'b0001_1000, 8'b0001_1000, 8'b0001_1000, 8'b0011_1100},
        '{8'b0000_0000, 8'b0011_1100, 8'b0110_0110, 8'b0000_0110,
          8'b0000_1100, 8'b0011_0000, 8'b0110_0000, 8'b0111_1110},
        '{8'b0000_0000, 8'b0011_1100, 8'b0110_0110, 8'b0000_0110,
          8'b0001_1100, 8'b0000_0110, 8'b0110_0110, 8'b0011_1100},
        '{8'b0000_0000, 8'b0000_1100, 8'b0001_1100, 8'b0010_1100,
          8'b0100_1100, 8'b0111_1110, 8'b0000_1100, 8'b0000_1100},
        '{8'b0000_0000, 8'b0111_1110, 8'b0110_0000, 8'b0111_1100,
          8'b0000_0110, 8'b0000_0110, 8'b0110_0110, 8'b0011_1100}
    };

endpackage
